/* hw/exu_cfg.svh */
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data path width that the word ops assume
`define EXU_XLEN 64

// data memory depth in 64-bit words, always a power of two
`define EXU_DMEM_WORDS 256

`endif

/* hw/exu_pkg.sv */
`include "exu_cfg.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;
  typedef logic [31:0] word_t;
  typedef logic [5:0] func_t;
  typedef logic [7:0] wmask_t;
  typedef logic [$clog2(`EXU_DMEM_WORDS)-1:0] dmem_idx_t;

  // integer ops shared with the immediate forms
  localparam func_t Add    = 6'd0;
  localparam func_t Sub    = 6'd1;
  localparam func_t And    = 6'd2;
  localparam func_t Or     = 6'd3;
  localparam func_t Xor    = 6'd4;
  localparam func_t Sll    = 6'd5;
  localparam func_t Srl    = 6'd6;
  localparam func_t Sra    = 6'd7;
  localparam func_t Slt    = 6'd8;
  localparam func_t Sltu   = 6'd9;
  localparam func_t Mul    = 6'd10;
  localparam func_t Divu   = 6'd11;
  localparam func_t Remu   = 6'd12;
  // word ops
  localparam func_t Addw   = 6'd13;
  localparam func_t Subw   = 6'd14;
  localparam func_t Sllw   = 6'd15;
  localparam func_t Srlw   = 6'd16;
  localparam func_t Sraw   = 6'd17;
  localparam func_t Mulw   = 6'd18;
  localparam func_t Divw   = 6'd19;
  localparam func_t Remw   = 6'd20;
  localparam func_t Lui    = 6'd21;
  localparam func_t Auipc  = 6'd22;
  // loads and stores
  localparam func_t Ld     = 6'd23;
  localparam func_t Lw     = 6'd24;
  localparam func_t Lwu    = 6'd25;
  localparam func_t Lh     = 6'd26;
  localparam func_t Lhu    = 6'd27;
  localparam func_t Lb     = 6'd28;
  localparam func_t Lbu    = 6'd29;
  localparam func_t Sd     = 6'd30;
  localparam func_t Sw     = 6'd31;
  localparam func_t Sh     = 6'd32;
  localparam func_t Sb     = 6'd33;
  // control flow
  localparam func_t Beq    = 6'd34;
  localparam func_t Bne    = 6'd35;
  localparam func_t Blt    = 6'd36;
  localparam func_t Bge    = 6'd37;
  localparam func_t Bltu   = 6'd38;
  localparam func_t Bgeu   = 6'd39;
  localparam func_t Jal    = 6'd40;
  localparam func_t Jalr   = 6'd41;
  // codes above this highest one are illegal
  localparam func_t Ebreak = 6'd42;

endpackage

/* hw/mem_if.sv */
interface mem_if import exu_pkg::*; ();

  dmem_idx_t addr;
  xlen_t     wdata;
  wmask_t    wmask;
  logic      we;
  xlen_t     rdata;

  modport lsu_side (
    output addr, wdata, wmask, we,
    input  rdata
  );

  modport mem_side (
    input  addr, wdata, wmask, we,
    output rdata
  );

endinterface

/* hw/alu.sv */
module alu import exu_pkg::*; (
  input  func_t func,
  input  xlen_t src1,
  input  xlen_t src2,
  output xlen_t alu_result
);

  logic [5:0] shamt;
  logic [4:0] shamt_w;
  word_t      src1_w;
  word_t      src2_w;
  xlen_t      divu_q;
  xlen_t      remu_r;
  word_t      divw_q;
  word_t      remw_r;

  function automatic xlen_t sext_w(input word_t w);
    return {{32{w[31]}}, w};
  endfunction

  assign shamt   = src2[5:0];
  assign shamt_w = src2[4:0];
  assign src1_w  = src1[31:0];
  assign src2_w  = src2[31:0];

  // unsigned divide with the ISA results for a zero divisor
  always_comb begin
    if (src2 == '0) begin
      divu_q = '1;
      remu_r = src1;
    end else begin
      divu_q = src1 / src2;
      remu_r = src1 % src2;
    end
  end

  // signed word divide with zero and overflow cases
  always_comb begin
    if (src2_w == '0) begin
      divw_q = '1;
      remw_r = src1_w;
    end else if (src1_w == 32'h8000_0000 && src2_w == 32'hffff_ffff) begin
      divw_q = src1_w;
      remw_r = '0;
    end else begin
      divw_q = word_t'($signed(src1_w) / $signed(src2_w));
      remw_r = word_t'($signed(src1_w) % $signed(src2_w));
    end
  end

  always_comb begin
    case (func)
      Add:     alu_result = src1 + src2;
      Sub:     alu_result = src1 - src2;
      And:     alu_result = src1 & src2;
      Or:      alu_result = src1 | src2;
      Xor:     alu_result = src1 ^ src2;
      Sll:     alu_result = src1 << shamt;
      Srl:     alu_result = src1 >> shamt;
      Sra:     alu_result = $signed(src1) >>> shamt;
      Slt:     alu_result = {63'b0, $signed(src1) < $signed(src2)};
      Sltu:    alu_result = {63'b0, src1 < src2};
      Mul:     alu_result = src1 * src2;
      Divu:    alu_result = divu_q;
      Remu:    alu_result = remu_r;
      Addw:    alu_result = sext_w(word_t'(src1_w + src2_w));
      Subw:    alu_result = sext_w(word_t'(src1_w - src2_w));
      Sllw:    alu_result = sext_w(word_t'(src1_w << shamt_w));
      Srlw:    alu_result = sext_w(word_t'(src1_w >> shamt_w));
      Sraw:    alu_result = sext_w(word_t'($signed(src1_w) >>> shamt_w));
      Mulw:    alu_result = sext_w(word_t'(src1_w * src2_w));
      Divw:    alu_result = sext_w(divw_q);
      Remw:    alu_result = sext_w(remw_r);
      default: alu_result = '0;
    endcase
  end

endmodule

/* hw/branch_unit.sv */
`include "exu_cfg.svh"

module branch_unit import exu_pkg::*; (
  input  func_t func,
  input  xlen_t src1,
  input  xlen_t src2,
  input  xlen_t imm,
  input  xlen_t pc,
  output xlen_t dnpc,
  output xlen_t link
);

  logic  take;
  xlen_t target;
  xlen_t jalr_sum;

  assign link     = pc + xlen_t'(4);
  assign target   = pc + imm;
  assign jalr_sum = src1 + imm;

  always_comb begin
    case (func)
      Beq:     take = (src1 == src2);
      Bne:     take = (src1 != src2);
      Blt:     take = ($signed(src1) < $signed(src2));
      Bge:     take = ($signed(src1) >= $signed(src2));
      Bltu:    take = (src1 < src2);
      Bgeu:    take = (src1 >= src2);
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    case (func)
      Beq, Bne, Blt, Bge, Bltu, Bgeu: dnpc = take ? target : link;
      Jal:     dnpc = target;
      // bit 0 of the jalr target is dropped
      Jalr:    dnpc = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
      default: dnpc = link;
    endcase
  end

endmodule

/* hw/lsu.sv */
module lsu import exu_pkg::*; (
  input  logic    rst,
  input  func_t   func,
  input  xlen_t   src1,
  input  xlen_t   src2,
  input  xlen_t   imm,
  output xlen_t   load_result,
  mem_if.lsu_side mem
);

  xlen_t      eff_addr;
  logic [2:0] offset;
  wmask_t     base_mask;
  logic       is_store;
  xlen_t      shifted;

  assign eff_addr = src1 + imm;
  assign offset   = eff_addr[2:0];

  // higher address bits wrap around the memory
  assign mem.addr = eff_addr[$bits(dmem_idx_t)+2:3];

  always_comb begin
    case (func)
      Sd:      base_mask = 8'hff;
      Sw:      base_mask = 8'h0f;
      Sh:      base_mask = 8'h03;
      Sb:      base_mask = 8'h01;
      default: base_mask = 8'h00;
    endcase
  end

  assign is_store  = (base_mask != '0);
  assign mem.we    = is_store && !rst;
  // lanes follow the byte offset
  assign mem.wmask = mem.we ? wmask_t'(base_mask << offset) : '0;
  assign mem.wdata = src2 << {offset, 3'b000};

  // bring the addressed byte down to lane 0
  assign shifted = mem.rdata >> {offset, 3'b000};

  always_comb begin
    case (func)
      Ld:      load_result = shifted;
      Lw:      load_result = {{32{shifted[31]}}, shifted[31:0]};
      Lwu:     load_result = {32'b0, shifted[31:0]};
      Lh:      load_result = {{48{shifted[15]}}, shifted[15:0]};
      Lhu:     load_result = {48'b0, shifted[15:0]};
      Lb:      load_result = {{56{shifted[7]}}, shifted[7:0]};
      Lbu:     load_result = {56'b0, shifted[7:0]};
      default: load_result = '0;
    endcase
  end

endmodule

/* hw/data_mem.sv */
`include "exu_cfg.svh"

module data_mem import exu_pkg::*; (
  input  logic    clk,
  mem_if.mem_side mem
);

  xlen_t ram [`EXU_DMEM_WORDS];

  // combinational read gives same-cycle data
  assign mem.rdata = ram[mem.addr];

  always_ff @(posedge clk) begin
    if (mem.we) begin
      for (int b = 0; b < 8; b++) begin
        if (mem.wmask[b]) begin
          ram[mem.addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* hw/exu_top.sv */
module exu_top import exu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  func_t func,
  input  xlen_t src1,
  input  xlen_t src2,
  input  xlen_t imm,
  input  xlen_t pc,
  output xlen_t result,
  output xlen_t dnpc,
  output logic  illegal,
  output logic  ebreak
);

  xlen_t alu_result;
  xlen_t load_result;
  xlen_t link;

  mem_if dmem_bus ();

  alu u_alu (
    .func       (func),
    .src1       (src1),
    .src2       (src2),
    .alu_result (alu_result)
  );

  branch_unit u_branch (
    .func (func),
    .src1 (src1),
    .src2 (src2),
    .imm  (imm),
    .pc   (pc),
    .dnpc (dnpc),
    .link (link)
  );

  lsu u_lsu (
    .rst         (rst),
    .func        (func),
    .src1        (src1),
    .src2        (src2),
    .imm         (imm),
    .load_result (load_result),
    .mem         (dmem_bus.lsu_side)
  );

  data_mem u_dmem (
    .clk (clk),
    .mem (dmem_bus.mem_side)
  );

  // codes are dense from zero up to Ebreak
  assign illegal = (func > Ebreak);
  assign ebreak  = (func == Ebreak);

  always_comb begin
    case (func)
      Ld, Lw, Lwu, Lh, Lhu, Lb, Lbu:  result = load_result;
      Jal, Jalr:                      result = link;
      Lui:                            result = imm;
      Auipc:                          result = pc + imm;
      Sd, Sw, Sh, Sb:                 result = '0;
      Beq, Bne, Blt, Bge, Bltu, Bgeu: result = '0;
      Ebreak:                         result = '0;
      // alu gives zero for illegal codes
      default:                        result = alu_result;
    endcase
  end

endmodule

/* tb/exu_checker.sv */
module exu_checker import exu_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   we,
  input wmask_t wmask,
  input logic   illegal,
  input logic   ebreak,
  input xlen_t  result
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // memory is frozen while in reset
  we_low_in_reset: assert property (@(posedge clk) rst |-> !we)
    else begin
      $error("write enable high during reset");
      fail_count++;
    end

  mask_idle: assert property (@(posedge clk) !we |-> wmask == '0)
    else begin
      $error("byte mask active without a write");
      fail_count++;
    end

  flags_exclusive: assert property (@(posedge clk) !(illegal && ebreak))
    else begin
      $error("illegal and ebreak raised together");
      fail_count++;
    end

  illegal_zero: assert property (@(posedge clk) illegal |-> result == '0)
    else begin
      $error("nonzero result on an illegal code");
      fail_count++;
    end

endmodule

bind exu_top exu_checker u_checker (
  .clk     (clk),
  .rst     (rst),
  .we      (dmem_bus.we),
  .wmask   (dmem_bus.wmask),
  .illegal (illegal),
  .ebreak  (ebreak),
  .result  (result)
);

/* tb/exu_tb.sv */
`include "exu_cfg.svh"

module exu_tb import exu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    func_t      func;
    logic [1:0] flags;
    xlen_t      src1;
    xlen_t      src2;
    xlen_t      imm;
    xlen_t      pc;
    xlen_t      res;
    xlen_t      npc;
  } vec_t;

  localparam int num_vecs = 36;

  logic  clk;
  logic  rst;
  func_t func;
  xlen_t src1;
  xlen_t src2;
  xlen_t imm;
  xlen_t pc;
  xlen_t result;
  xlen_t dnpc;
  logic  illegal;
  logic  ebreak;

  int         checks = 0;
  int         errors = 0;
  logic       stim_done = 1'b0;
  logic [7:0] shadow [`EXU_DMEM_WORDS*8];

  func_t rand_ops [10] = '{Add, Sub, Sll, Sra, Slt, Sltu, Mul, Addw, Sraw, Mulw};

  // flags column is {illegal, ebreak}
  vec_t vectors [num_vecs] = '{
    '{Divu, 2'b00, 'h1234, '0, '0, 'h1000, '1, 'h1004},
    '{Remu, 2'b00, 'h1234, '0, '0, 'h1000, 'h1234, 'h1004},
    '{Divw, 2'b00, 'h55, 64'h1_0000_0000, '0, 'h1000, '1, 'h1004},
    '{Remw, 2'b00, 'h8000_0005, '0, '0, 'h1000, 64'hffff_ffff_8000_0005, 'h1004},
    '{Divw, 2'b00, 'h8000_0000, 'hffff_ffff, '0, 'h1000, 64'hffff_ffff_8000_0000, 'h1004},
    '{Remw, 2'b00, 'h8000_0000, 'hffff_ffff, '0, 'h1000, '0, 'h1004},
    // stores and loads all land in word 0x20
    '{Sd, 2'b00, 'h100, 64'h1122_3344_5566_7788, '0, 'h1000, '0, 'h1004},
    '{Ld, 2'b00, 'h100, '0, '0, 'h1000, 64'h1122_3344_5566_7788, 'h1004},
    '{Sw, 2'b00, 'h100, 64'hffff_0000_89ab_cdef, 'h4, 'h1000, '0, 'h1004},
    '{Lw, 2'b00, 'h100, '0, 'h4, 'h1000, 64'hffff_ffff_89ab_cdef, 'h1004},
    '{Lwu, 2'b00, 'hf0, '0, 'h14, 'h1000, 'h89ab_cdef, 'h1004},
    '{Sh, 2'b00, 'h102, 'h8001, '0, 'h1000, '0, 'h1004},
    '{Lh, 2'b00, 'h102, '0, '0, 'h1000, 64'hffff_ffff_ffff_8001, 'h1004},
    '{Lhu, 2'b00, 'h104, '0, 64'hffff_ffff_ffff_fffe, 'h1000, 'h8001, 'h1004},
    '{Sb, 2'b00, 'h107, 'h12f0, '0, 'h1000, '0, 'h1004},
    '{Lb, 2'b00, 'h107, '0, '0, 'h1000, 64'hffff_ffff_ffff_fff0, 'h1004},
    '{Lbu, 2'b00, 'h105, '0, '0, 'h1000, 'hcd, 'h1004},
    // 0x900 wraps onto the same word
    '{Ld, 2'b00, 'h900, '0, '0, 'h1000, 64'hf0ab_cdef_8001_7788, 'h1004},
    '{Beq, 2'b00, 'h5, 'h5, 'h40, 'h2000, '0, 'h2040},
    '{Beq, 2'b00, 'h5, 'h6, 'h40, 'h2000, '0, 'h2004},
    '{Bne, 2'b00, 'h5, 'h6, 'h40, 'h2000, '0, 'h2040},
    '{Bne, 2'b00, 'h5, 'h5, 'h40, 'h2000, '0, 'h2004},
    '{Blt, 2'b00, '1, 'h1, 64'hffff_ffff_ffff_fff8, 'h2000, '0, 'h1ff8},
    '{Blt, 2'b00, 'h1, '1, 'h40, 'h2000, '0, 'h2004},
    '{Bge, 2'b00, 'h1, '1, 'h40, 'h2000, '0, 'h2040},
    '{Bge, 2'b00, '1, 'h1, 'h40, 'h2000, '0, 'h2004},
    '{Bltu, 2'b00, 'h1, '1, 'h40, 'h2000, '0, 'h2040},
    '{Bltu, 2'b00, '1, 'h1, 'h40, 'h2000, '0, 'h2004},
    '{Bgeu, 2'b00, '1, 'h1, 'h40, 'h2000, '0, 'h2040},
    '{Bgeu, 2'b00, 'h1, '1, 'h40, 'h2000, '0, 'h2004},
    '{Jal, 2'b00, '0, '0, 'h100, 'h2000, 'h2004, 'h2100},
    '{Jalr, 2'b00, 'h3001, '0, 'h10, 'h2000, 'h2004, 'h3010},
    '{Lui, 2'b00, '0, '0, 64'hffff_ffff_8765_4000, 'h1000, 64'hffff_ffff_8765_4000, 'h1004},
    '{Auipc, 2'b00, '0, '0, 'h1000, 'h1000, 'h2000, 'h1004},
    '{6'd50, 2'b10, 'h3, 'h4, '0, 'h1000, '0, 'h1004},
    '{Ebreak, 2'b01, '0, '0, '0, 'h1000, '0, 'h1004}
  };

  exu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic xlen_t sext32(input word_t w);
    return xlen_t'($signed(w));
  endfunction

  // expected alu results straight from the ISA rules
  function automatic xlen_t model_alu(input func_t f, input xlen_t a, input xlen_t b);
    xlen_t r;
    case (f)
      Add:     r = a + b;
      Sub:     r = a + ~b + 64'd1;
      Sll:     r = a << b[5:0];
      Sra:     r = (a >> b[5:0]) | (a[63] ? ~(~64'd0 >> b[5:0]) : 64'd0);
      Slt:     r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      Sltu:    r = (a < b) ? 64'd1 : 64'd0;
      Mul:     r = a * b;
      Addw:    r = sext32(a[31:0] + b[31:0]);
      Sraw:    r = sext32(word_t'(sext32(a[31:0]) >> b[4:0]));
      Mulw:    r = sext32(word_t'(a * b));
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic track_store(input func_t f, input xlen_t addr, input xlen_t data);
    int nbytes;
    int base;
    int off;
    nbytes = (f == Sd) ? 8 : (f == Sw) ? 4 : (f == Sh) ? 2 : 1;
    base   = int'((addr >> 3) % `EXU_DMEM_WORDS) * 8;
    off    = int'(addr[2:0]);
    // bytes past the end of the word are lost
    for (int b = 0; b < nbytes; b++) begin
      if (off + b < 8) begin
        shadow[base + off + b] = data[b*8 +: 8];
      end
    end
  endtask

  function automatic xlen_t shadow_word(input xlen_t addr);
    xlen_t w;
    int    base;
    base = int'((addr >> 3) % `EXU_DMEM_WORDS) * 8;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = shadow[base + b];
    end
    return w;
  endfunction

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // apply at the rising edge and sample after the outputs settle
  task automatic drive_op(input func_t f, input xlen_t a, input xlen_t b, input xlen_t i,
                          input xlen_t p);
    @(posedge clk);
    func <= f;
    src1 <= a;
    src2 <= b;
    imm  <= i;
    pc   <= p;
    @(negedge clk);
  endtask

  initial begin : stimulus
    vec_t  v;
    func_t f;
    xlen_t a;
    xlen_t b;
    xlen_t p;
    void'($urandom(32'h64c0_dd6c));
    rst  = 1'b1;
    func = Add;
    src1 = '0;
    src2 = '0;
    imm  = '0;
    pc   = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_vecs; i++) begin
      v = vectors[i];
      drive_op(v.func, v.src1, v.src2, v.imm, v.pc);
      if (v.func inside {Sd, Sw, Sh, Sb}) begin
        track_store(v.func, v.src1 + v.imm, v.src2);
      end
      check_xlen("result", v.res, result);
      check_xlen("dnpc", v.npc, dnpc);
      check_flag("illegal", v.flags[1], illegal);
      check_flag("ebreak", v.flags[0], ebreak);
    end
    for (int n = 0; n < 60; n++) begin
      f = rand_ops[$urandom_range(9, 0)];
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      p = {$urandom, $urandom};
      drive_op(f, a, b, '0, p);
      check_xlen("result", model_alu(f, a, b), result);
      check_xlen("dnpc", p + 64'd4, dnpc);
    end
    // a store held through a reset pulse must not reach memory
    @(posedge clk);
    rst  <= 1'b1;
    func <= Sd;
    src1 <= 'h100;
    src2 <= 64'hdead_beef_0bad_f00d;
    imm  <= '0;
    repeat (2) @(posedge clk);
    // idle add as reset drops
    rst  <= 1'b0;
    func <= Add;
    src1 <= '0;
    src2 <= '0;
    drive_op(Ld, 'h100, '0, '0, 'h1000);
    check_xlen("result", shadow_word('h100), result);
    stim_done = 1'b1;
  end

  initial begin : closing
    int waited;
    waited = 0;
    while (!stim_done && waited < 2000) begin
      @(posedge clk);
      waited++;
    end
    if (!stim_done) begin
      $display("timeout: stimulus did not finish within %0d cycles", waited);
      errors++;
    end
    errors += dut.u_checker.fail_count;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/exu_pkg.sv
hw/mem_if.sv
hw/alu.sv
hw/branch_unit.sv
hw/lsu.sv
hw/data_mem.sv
hw/exu_top.sv
tb/exu_checker.sv
tb/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module exu_tb \
  -f flist.f -o exu_sim > build.log 2>&1 &&
  ./obj_dir/exu_sim +verilator+error+limit+100 > sim.log 2>&1 ||
  echo "build or simulation returned an error, see build.log and sim.log"
grep -qx "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
